// ==== list.f ====
+incdir+common
common/etx_pkg.sv
hw/etx/etx_fifo.sv
hw/etx/etx_arbiter.sv
hw/etx/etx_io.sv
hw/elink_tx.sv
sim/elink_tx_props.sv
sim/tb_elink_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the elink_tx testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert -j 0 \
   --top-module tb_elink_tx --Mdir "$build_dir" -f list.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/Vtb_elink_tx" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qx "Test OK" "$log_file"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

// ==== sim/tb_elink_tx.sv ====
`timescale 1ns/1ps
`include "etx_settings.svh"

module tb_elink_tx;

   import etx_pkg::*;

   // Seven beats, index 0 is the first beat on the link
   typedef logic [6:0][15:0] frame_t;

   // About 40 packets of eight cycles plus stalls, with wide margin
   localparam int TIMEOUT_CYCLES = 5000;

   logic          tx_lclk;
   logic          reset;
   logic          txwr_access;
   emesh_packet_t txwr_packet;
   logic          txwr_wait;
   logic          txrd_access;
   etx_rdreq_t    txrd_packet;
   logic          txrd_wait;
   logic          txi_wr_wait;
   logic          txi_rd_wait;
   logic          txo_frame;
   etx_beat_t     txo_data;

   integer        seed = 92856;
   int            cycle_count = 0;
   int            beat_errors = 0;
   int            packet_errors = 0;
   int            flag_errors = 0;
   int            other_errors = 0;
   logic [3:0]    beat_count = '0;
   frame_t        cur_frame;
   frame_t        frame_q[$];
   emesh_packet_t exp_wr_q[$];
   emesh_packet_t exp_rd_q[$];

   elink_tx elink_tx_i (
      .tx_lclk     (tx_lclk),
      .reset       (reset),
      .txwr_access (txwr_access),
      .txwr_packet (txwr_packet),
      .txwr_wait   (txwr_wait),
      .txrd_access (txrd_access),
      .txrd_packet (txrd_packet),
      .txrd_wait   (txrd_wait),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait),
      .txo_frame   (txo_frame),
      .txo_data    (txo_data)
   );

   initial tx_lclk = 1'b0;
   always #10 tx_lclk = ~tx_lclk;

   // ################################################
   // Stimulus and reference model
   // ################################################

   function automatic logic [31:0] rand32();
      logic [31:0] r;
      r = $random(seed);
      return r;
   endfunction

   function automatic emesh_packet_t random_write();
      emesh_packet_t p;
      logic [31:0]   r;
      r          = rand32();
      p.ctrlmode = r[3:0];
      p.datamode = r[5:4];
      p.access   = r[6];
      p.write    = 1'b1;
      p.dstaddr  = rand32();
      p.data     = rand32();
      p.srcaddr  = rand32();
      return p;
   endfunction

   function automatic etx_rdreq_t random_read();
      etx_rdreq_t  q;
      logic [31:0] r;
      r          = rand32();
      q.ctrlmode = r[3:0];
      q.datamode = r[5:4];
      q.dstaddr  = rand32();
      q.srcaddr  = rand32();
      return q;
   endfunction

   // Read goes out as a full packet with no data
   function automatic emesh_packet_t read_as_packet(input etx_rdreq_t q);
      return '{ctrlmode: q.ctrlmode, dstaddr: q.dstaddr, datamode: q.datamode,
               write: 1'b0, access: 1'b1, data: 32'h0, srcaddr: q.srcaddr};
   endfunction

   function automatic frame_t expected_frame(input emesh_packet_t p);
      frame_t f;
      f[0] = {~p.write, 7'b0, p.ctrlmode, p.dstaddr[31:28]};
      f[1] = p.dstaddr[27:12];
      f[2] = {p.dstaddr[11:0], p.datamode, p.write, p.access};
      f[3] = p.data[31:16];
      f[4] = p.data[15:0];
      f[5] = p.srcaddr[31:16];
      f[6] = p.srcaddr[15:0];
      return f;
   endfunction

   function automatic emesh_packet_t frame_packet(input frame_t f);
      emesh_packet_t p;
      p.ctrlmode = f[0][7:4];
      p.dstaddr  = {f[0][3:0], f[1], f[2][15:4]};
      p.datamode = f[2][3:2];
      p.write    = f[2][1];
      p.access   = f[2][0];
      p.data     = {f[3], f[4]};
      p.srcaddr  = {f[5], f[6]};
      return p;
   endfunction

   task automatic check_beat(input string name, input etx_beat_t got, input etx_beat_t exp);
      if (got !== exp)
      begin
         beat_errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_packet(input string name, input emesh_packet_t got,
                               input emesh_packet_t exp);
      if (got !== exp)
      begin
         packet_errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         flag_errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // Fabric handshake, accepted on an edge with wait low
   task automatic push_write(input emesh_packet_t p);
      logic accepted;
      @(posedge tx_lclk);
      txwr_access <= 1'b1;
      txwr_packet <= p;
      accepted = 1'b0;
      while (!accepted)
      begin
         @(negedge tx_lclk);
         accepted = ~txwr_wait;
         @(posedge tx_lclk);
      end
      txwr_access <= 1'b0;
      // Sent with access forced high
      p.access = 1'b1;
      exp_wr_q.push_back(p);
   endtask

   task automatic push_read(input etx_rdreq_t q);
      logic accepted;
      @(posedge tx_lclk);
      txrd_access <= 1'b1;
      txrd_packet <= q;
      accepted = 1'b0;
      while (!accepted)
      begin
         @(negedge tx_lclk);
         accepted = ~txrd_wait;
         @(posedge tx_lclk);
      end
      txrd_access <= 1'b0;
      exp_rd_q.push_back(read_as_packet(q));
   endtask

   task automatic wait_frames(input int n);
      int waited;
      waited = 0;
      while (frame_q.size() < n && waited < n * 12 + 40)
      begin
         @(posedge tx_lclk);
         waited++;
      end
      if (frame_q.size() < n)
      begin
         other_errors++;
         $display("Missing frame: expected %0d frames, received %0d", n, frame_q.size());
      end
   endtask

   task automatic check_next_frame(input logic want_write);
      frame_t        f;
      frame_t        e;
      emesh_packet_t p;
      logic [2:0]    i;
      if (frame_q.size() == 0)
         return;
      f = frame_q.pop_front();
      if ((want_write && exp_wr_q.size() == 0) || (!want_write && exp_rd_q.size() == 0))
      begin
         other_errors++;
         $display("Frame received with no accepted packet left to match it");
         return;
      end
      if (want_write)
         p = exp_wr_q.pop_front();
      else
         p = exp_rd_q.pop_front();
      e = expected_frame(p);
      for (i = 3'd0; i < 3'd7; i++)
         check_beat($sformatf("txo_data beat %0d", i + 3'd1), f[i], e[i]);
      check_packet("packet rebuilt from txo_data", frame_packet(f), p);
   endtask

   // ################################################
   // Frame monitor and watchdog
   // ################################################

   always @(negedge tx_lclk)
   begin
      if (!reset && txo_frame)
      begin
         if (beat_count < 4'd7)
            cur_frame[beat_count[2:0]] = txo_data;
         beat_count = beat_count + 4'd1;
      end
      else if (!reset)
      begin
         check_beat("txo_data outside a frame", txo_data, '0);
         if (beat_count == 4'd7)
            frame_q.push_back(cur_frame);
         else if (beat_count != 4'd0)
         begin
            other_errors++;
            $display("Frame of %0d beats seen, a frame must have seven", beat_count);
         end
         beat_count = 4'd0;
      end
   end

   initial
   begin
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge tx_lclk);
         cycle_count++;
      end
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   // ################################################
   // Directed tests
   // ################################################

   task automatic send_one_write();
      push_write(random_write());
      wait_frames(1);
      check_next_frame(1'b1);
   endtask

   task automatic send_one_read();
      push_read(random_read());
      wait_frames(1);
      check_next_frame(1'b0);
   endtask

   // Both channels loaded on the same edges, reads must drain first
   task automatic check_read_priority();
      emesh_packet_t wr_list[$];
      etx_rdreq_t    rd_list[$];
      repeat (3)
      begin
         wr_list.push_back(random_write());
         rd_list.push_back(random_read());
      end
      fork
         while (wr_list.size() != 0) push_write(wr_list.pop_front());
         while (rd_list.size() != 0) push_read(rd_list.pop_front());
      join
      wait_frames(6);
      repeat (3) check_next_frame(1'b0);
      repeat (3) check_next_frame(1'b1);
   endtask

   task automatic hold_write_channel();
      @(posedge tx_lclk);
      txi_wr_wait <= 1'b1;
      // Pushback through the synchronizer first
      repeat (4) @(posedge tx_lclk);
      push_write(random_write());
      push_write(random_write());
      push_read(random_read());
      push_read(random_read());
      wait_frames(2);
      repeat (2) check_next_frame(1'b0);
      repeat (40) @(posedge tx_lclk);
      if (frame_q.size() != 0)
      begin
         other_errors++;
         $display("A frame was sent while the remote write wait was high");
      end
      txi_wr_wait <= 1'b0;
      wait_frames(2);
      repeat (2) check_next_frame(1'b1);
   endtask

   task automatic fill_write_queue();
      @(posedge tx_lclk);
      txi_wr_wait <= 1'b1;
      repeat (4) @(posedge tx_lclk);
      repeat (`ETX_FIFO_DEPTH)
      begin
         @(negedge tx_lclk);
         check_flag("txwr_wait", txwr_wait, 1'b0);
         push_write(random_write());
      end
      @(negedge tx_lclk);
      check_flag("txwr_wait", txwr_wait, 1'b1);
      @(posedge tx_lclk);
      txi_wr_wait <= 1'b0;
      wait_frames(1);
      @(negedge tx_lclk);
      check_flag("txwr_wait", txwr_wait, 1'b0);
      wait_frames(`ETX_FIFO_DEPTH);
      repeat (`ETX_FIFO_DEPTH) check_next_frame(1'b1);
   endtask

   task automatic send_random_mix();
      logic [31:0] r;
      repeat (20)
      begin
         r = rand32();
         if (r[0])
            push_write(random_write());
         else
            push_read(random_read());
         repeat (r[2:1]) @(posedge tx_lclk);
      end
      wait_frames(20);
      repeat (30) @(posedge tx_lclk);
      if (frame_q.size() != 20)
      begin
         other_errors++;
         $display("Received %0d frames for 20 accepted packets", frame_q.size());
      end
      // Channel taken from the write bit of beat 3
      while (frame_q.size() != 0)
         check_next_frame(frame_q[0][2][1]);
      if (exp_wr_q.size() + exp_rd_q.size() != 0)
      begin
         other_errors++;
         $display("Accepted packets never appeared on the link");
      end
   endtask

   initial
   begin
      reset       = 1'b1;
      txwr_access = 1'b0;
      txwr_packet = '0;
      txrd_access = 1'b0;
      txrd_packet = '0;
      txi_wr_wait = 1'b0;
      txi_rd_wait = 1'b0;
      repeat (8) @(posedge tx_lclk);
      reset <= 1'b0;
      @(negedge tx_lclk);
      check_flag("txo_frame", txo_frame, 1'b0);
      check_beat("txo_data", txo_data, '0);
      check_flag("txwr_wait", txwr_wait, 1'b0);
      check_flag("txrd_wait", txrd_wait, 1'b0);
      send_one_write();
      send_one_read();
      check_read_priority();
      hold_write_channel();
      fill_write_queue();
      send_random_mix();
      repeat (20) @(posedge tx_lclk);
      $display("Errors: beat %0d, packet %0d, flag %0d, other %0d",
               beat_errors, packet_errors, flag_errors, other_errors);
      if (beat_errors + packet_errors + flag_errors + other_errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== sim/elink_tx_props.sv ====
`timescale 1ns/1ps

module elink_tx_props (
   input logic                tx_lclk,
   input logic                reset,
   input etx_pkg::etx_state_t state,
   input logic                io_access,
   input logic                io_wait,
   input logic                txo_frame,
   input etx_pkg::etx_beat_t  txo_data
);

   import etx_pkg::*;

   // Frame cycles seen so far in the current run
   logic [3:0] run_len;

   always_ff @(posedge tx_lclk)
   begin
      if (reset)
         run_len <= '0;
      else if (txo_frame)
         run_len <= (run_len == 4'd15) ? run_len : run_len + 4'd1;
      else
         run_len <= '0;
   end

   // ################################################
   // Frame shape and idle outputs
   // ################################################

   frame_not_long: assert property (@(posedge tx_lclk) disable iff (reset)
      txo_frame |-> run_len < 4'd7)
      else $error("txo_frame high for more than seven cycles");

   frame_not_short: assert property (@(posedge tx_lclk) disable iff (reset)
      (!txo_frame && run_len != 4'd0) |-> run_len == 4'd7)
      else $error("txo_frame dropped before seven cycles");

   idle_data_zero: assert property (@(posedge tx_lclk) disable iff (reset)
      !txo_frame |-> txo_data == '0)
      else $error("txo_data not zero outside a frame");

   // Accept cycle plus seven busy states, then free again
   idle_after_packet: assert property (@(posedge tx_lclk) disable iff (reset)
      $past(io_access && !io_wait, 8) |-> (state == IDLE && !io_wait))
      else $error("sequencer not idle with io_wait low eight cycles after an accept");

endmodule

bind etx_io elink_tx_props props_i (
   .tx_lclk   (tx_lclk),
   .reset     (reset),
   .state     (state),
   .io_access (io_access),
   .io_wait   (io_wait),
   .txo_frame (txo_frame),
   .txo_data  (txo_data)
);

// ==== hw/elink_tx.sv ====
`timescale 1ns/1ps

module elink_tx (
   input  logic                   tx_lclk,
   input  logic                   reset,
   input  logic                   txwr_access,
   input  etx_pkg::emesh_packet_t txwr_packet,
   output logic                   txwr_wait,
   input  logic                   txrd_access,
   input  etx_pkg::etx_rdreq_t    txrd_packet,
   output logic                   txrd_wait,
   input  logic                   txi_wr_wait,
   input  logic                   txi_rd_wait,
   output logic                   txo_frame,
   output etx_pkg::etx_beat_t     txo_data
);

   import etx_pkg::*;

   logic          wr_valid;
   emesh_packet_t wr_head;
   logic          wr_take;
   logic          rd_valid;
   etx_rdreq_t    rd_head;
   logic          rd_take;
   logic          io_access;
   emesh_packet_t io_packet;
   logic          io_wait;

   // ################################################
   // Fabric queues
   // ################################################

   etx_fifo #(.T(emesh_packet_t)) wr_fifo (
      .tx_lclk   (tx_lclk),
      .reset     (reset),
      .in_access (txwr_access),
      .in_entry  (txwr_packet),
      .in_wait   (txwr_wait),
      .out_valid (wr_valid),
      .out_entry (wr_head),
      .out_take  (wr_take)
   );

   // Read requests kept narrow
   etx_fifo #(.T(etx_rdreq_t)) rd_fifo (
      .tx_lclk   (tx_lclk),
      .reset     (reset),
      .in_access (txrd_access),
      .in_entry  (txrd_packet),
      .in_wait   (txrd_wait),
      .out_valid (rd_valid),
      .out_entry (rd_head),
      .out_take  (rd_take)
   );

   // ################################################
   // Arbiter and serializer
   // ################################################

   etx_arbiter arbiter_i (
      .tx_lclk     (tx_lclk),
      .reset       (reset),
      .wr_valid    (wr_valid),
      .wr_entry    (wr_head),
      .wr_take     (wr_take),
      .rd_valid    (rd_valid),
      .rd_entry    (rd_head),
      .rd_take     (rd_take),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait),
      .io_access   (io_access),
      .io_packet   (io_packet),
      .io_wait     (io_wait)
   );

   etx_io io_i (
      .tx_lclk   (tx_lclk),
      .reset     (reset),
      .io_access (io_access),
      .io_packet (io_packet),
      .io_wait   (io_wait),
      .txo_frame (txo_frame),
      .txo_data  (txo_data)
   );

endmodule

// ==== hw/etx/etx_io.sv ====
`timescale 1ns/1ps

module etx_io (
   input  logic                   tx_lclk,
   input  logic                   reset,
   input  logic                   io_access,
   input  etx_pkg::emesh_packet_t io_packet,
   output logic                   io_wait,
   output logic                   txo_frame,
   output etx_pkg::etx_beat_t     txo_data
);

   import etx_pkg::*;

   etx_state_t    state;
   etx_state_t    state_reg;
   emesh_packet_t packet_reg;
   etx_stage_t    stage;
   logic          accept;

   // Busy for the whole frame, free only in IDLE
   assign io_wait = (state != IDLE);
   assign accept  = io_access & ~io_wait;

   // ################################################
   // Transmit sequencer
   // ################################################

   always_ff @(posedge tx_lclk)
   begin
      if (reset)
         state <= IDLE;
      else
      begin
         case (state)
            IDLE:   state <= accept ? CYCLE1 : IDLE;
            CYCLE1: state <= CYCLE2;
            CYCLE2: state <= CYCLE3;
            CYCLE3: state <= CYCLE4;
            CYCLE4: state <= CYCLE5;
            CYCLE5: state <= CYCLE6;
            CYCLE6: state <= CYCLE7;
            CYCLE7: state <= IDLE;
         endcase
      end
   end

   // ################################################
   // Packet and staging registers
   // ################################################

   always_ff @(posedge tx_lclk)
   begin
      if (accept)
         packet_reg <= io_packet;
   end

   // Header word first, payload word swapped in at CYCLE4
   // Upper beat of the header word is unused
   always_ff @(posedge tx_lclk)
   begin
      if (state == CYCLE1)
         stage <= {16'b0,
                   ~packet_reg.write, 7'b0, packet_reg.ctrlmode,
                   packet_reg.dstaddr, packet_reg.datamode,
                   packet_reg.write, packet_reg.access};
      else if (state == CYCLE4)
         stage <= {packet_reg.data, packet_reg.srcaddr};
   end

   // ################################################
   // Beat select and frame
   // ################################################

   // Delayed state lines up with the staging word
   always_ff @(posedge tx_lclk)
   begin
      if (reset)
      begin
         state_reg <= IDLE;
         txo_frame <= 1'b0;
         txo_data  <= '0;
      end
      else
      begin
         state_reg <= state;
         txo_frame <= (state_reg != IDLE);
         case (state_reg)
            CYCLE1,
            CYCLE5:  txo_data <= stage[47:32];
            CYCLE2,
            CYCLE6:  txo_data <= stage[31:16];
            CYCLE3,
            CYCLE7:  txo_data <= stage[15:0];
            CYCLE4:  txo_data <= stage[63:48];
            // Quiet bus outside a frame
            default: txo_data <= '0;
         endcase
      end
   end

endmodule

// ==== hw/etx/etx_arbiter.sv ====
`timescale 1ns/1ps
`include "etx_settings.svh"

module etx_arbiter (
   input  logic                   tx_lclk,
   input  logic                   reset,
   input  logic                   wr_valid,
   input  etx_pkg::emesh_packet_t wr_entry,
   output logic                   wr_take,
   input  logic                   rd_valid,
   input  etx_pkg::etx_rdreq_t    rd_entry,
   output logic                   rd_take,
   input  logic                   txi_wr_wait,
   input  logic                   txi_rd_wait,
   output logic                   io_access,
   output etx_pkg::emesh_packet_t io_packet,
   input  logic                   io_wait
);

   import etx_pkg::*;

   localparam int SYNC_STAGES = `ETX_SYNC_STAGES;

   logic [SYNC_STAGES-1:0] wr_wait_sync;
   logic [SYNC_STAGES-1:0] rd_wait_sync;
   logic                   wr_ready;
   logic                   rd_ready;
   logic                   accept;
   logic                   load;
   logic                   sel_rd;
   emesh_packet_t          wr_packet;

   // Read request to full packet
   function automatic emesh_packet_t widen_rdreq(input etx_rdreq_t req);
      emesh_packet_t pkt;
      pkt.ctrlmode = req.ctrlmode;
      pkt.dstaddr  = req.dstaddr;
      pkt.datamode = req.datamode;
      pkt.write    = 1'b0;
      pkt.access   = 1'b1;
      pkt.data     = '0;
      pkt.srcaddr  = req.srcaddr;
      return pkt;
   endfunction

   // ################################################
   // Remote pushback synchronizers
   // ################################################

   always_ff @(posedge tx_lclk)
   begin
      if (reset)
      begin
         wr_wait_sync <= '0;
         rd_wait_sync <= '0;
      end
      else
      begin
         wr_wait_sync <= {wr_wait_sync[SYNC_STAGES-2:0], txi_wr_wait};
         rd_wait_sync <= {rd_wait_sync[SYNC_STAGES-2:0], txi_rd_wait};
      end
   end

   // ################################################
   // Channel choice
   // ################################################

   // A blocked channel is never picked, the other one still is
   assign wr_ready = wr_valid & ~wr_wait_sync[SYNC_STAGES-1];
   assign rd_ready = rd_valid & ~rd_wait_sync[SYNC_STAGES-1];

   assign accept = io_access & ~io_wait;
   assign load   = ~io_access;

   // Writes go out as queued but always marked valid
   always_comb
   begin
      wr_packet        = wr_entry;
      wr_packet.access = 1'b1;
   end

   // Offer is dropped for one cycle after acceptance
   // so the popped queue head has settled before the next pick
   always_ff @(posedge tx_lclk)
   begin
      if (reset)
      begin
         io_access <= 1'b0;
         sel_rd    <= 1'b0;
      end
      else if (accept)
         io_access <= 1'b0;
      else if (load)
      begin
         io_access <= rd_ready | wr_ready;
         // Reads win a tie
         sel_rd    <= rd_ready;
      end
   end

   always_ff @(posedge tx_lclk)
   begin
      if (load)
         io_packet <= rd_ready ? widen_rdreq(rd_entry) : wr_packet;
   end

   // Pop the chosen queue as the serializer takes the packet
   assign wr_take = accept & ~sel_rd;
   assign rd_take = accept & sel_rd;

endmodule

// ==== hw/etx/etx_fifo.sv ====
`timescale 1ns/1ps
`include "etx_settings.svh"

module etx_fifo #(
   parameter type T     = logic,
   parameter int  DEPTH = `ETX_FIFO_DEPTH
) (
   input  logic tx_lclk,
   input  logic reset,
   input  logic in_access,
   input  T     in_entry,
   output logic in_wait,
   output logic out_valid,
   output T     out_entry,
   input  logic out_take
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   T              mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          full;
   logic          push;
   logic          pop;

   // Pointer step with wrap for any depth
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      if (ptr == AW'(DEPTH - 1))
         return '0;
      else
         return ptr + AW'(1);
   endfunction

   assign full      = (count == CW'(DEPTH));
   assign push      = in_access & ~full;
   assign pop       = out_valid & out_take;
   assign in_wait   = full;
   assign out_valid = (count != '0);
   assign out_entry = mem[rd_ptr];

   // Storage
   always_ff @(posedge tx_lclk)
   begin
      if (push)
         mem[wr_ptr] <= in_entry;
   end

   // Pointers and occupancy
   always_ff @(posedge tx_lclk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + CW'(1);
            2'b01:   count <= count - CW'(1);
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== common/etx_pkg.sv ====
package etx_pkg;

   // ################################################
   // Link transaction
   // ################################################

   // Full 104-bit mesh transaction, high field first
   typedef struct packed {
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [1:0]  datamode;
      logic        write;
      logic        access;
      logic [31:0] data;
      logic [31:0] srcaddr;
   } emesh_packet_t;

   // Read request as queued
   // No data and no write bit, widened later by the arbiter
   typedef struct packed {
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [1:0]  datamode;
      logic [31:0] srcaddr;
   } etx_rdreq_t;

   // ################################################
   // Serializer helpers
   // ################################################

   // One beat on the link, stands for two DDR bytes
   typedef logic [15:0] etx_beat_t;

   // Staging word, four beats wide
   typedef logic [63:0] etx_stage_t;

   // Transmit sequencer states
   typedef enum logic [2:0] {
      IDLE   = 3'd0,
      CYCLE1 = 3'd1,
      CYCLE2 = 3'd2,
      CYCLE3 = 3'd3,
      CYCLE4 = 3'd4,
      CYCLE5 = 3'd5,
      CYCLE6 = 3'd6,
      CYCLE7 = 3'd7
   } etx_state_t;

endpackage

// ==== common/etx_settings.svh ====
`ifndef ETX_SETTINGS_SVH
`define ETX_SETTINGS_SVH

// ################################################
// Transmit link build settings
// ################################################

// Entries in each fabric queue
`define ETX_FIFO_DEPTH 4

// Flops on each remote pushback line
// Must be two or more
`define ETX_SYNC_STAGES 2

`endif
